//--- design/fetch_decode_reg.sv
// decode instruction register, fetch done flag, bus error flag
// and early register file addresses
module fetch_decode_reg
   import fetch_pkg::*;
(
   input  logic     clk,
   input  logic     rst,
   input  logic     padv_i,
   input  logic     branch_occur_i,
   input  logic     except_take_i,
   input  logic     ibus_err_i,
   input  logic     ibus_req_i,
   input  insn_t    insn_buf_i,
   input  logic     insn_buffered_i,
   input  logic     bus_done_r_i,
   output insn_t    decode_insn_o,
   output logic     decode_ibus_err_o,
   output logic     fetch_done_o,
   output rf_addr_t fetch_rfa_adr_o,
   output rf_addr_t fetch_rfb_adr_o
);

   insn_t decode_insn_q;
   logic  ibus_err_q;
   logic  branch_occur_r;
   logic  adv_into_branch;

   // the next word is ready if it just came off the bus or sits in the buffer
   // right after advancing into a branch, whatever was in flight is stale
   assign fetch_done_o = (bus_done_r_i | insn_buffered_i) & ~adv_into_branch;

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         branch_occur_r <= 1'b0;
         adv_into_branch <= 1'b0;
      end
      else
      begin
         branch_occur_r <= branch_occur_i;
         adv_into_branch <= padv_i & fetch_done_o & branch_occur_i;
      end
   end

   // exception entry flushes decode with a nop
   // otherwise load on advance, unless the last cycle redirected
   always_ff @(posedge clk)
   begin
      if (rst)
         decode_insn_q <= NOP_INSN;
      else if (except_take_i)
         decode_insn_q <= NOP_INSN;
      else if (padv_i & fetch_done_o & ~branch_occur_r)
         decode_insn_q <= insn_buf_i;
   end

   // bus error travels with the word to decode
   // sampled only while requesting and dropped on a taken branch
   always_ff @(posedge clk)
   begin
      if (rst)
         ibus_err_q <= 1'b0;
      else if (padv_i & branch_occur_i)
         ibus_err_q <= 1'b0;
      else if (ibus_req_i)
         ibus_err_q <= ibus_err_i;
   end

   assign decode_insn_o = decode_insn_q;
   assign decode_ibus_err_o = ibus_err_q;

   // early operand addresses straight from the buffered word
   assign fetch_rfa_adr_o = insn_buf_i[RA_LSB +: RF_ADDR_W];
   assign fetch_rfb_adr_o = insn_buf_i[RB_LSB +: RF_ADDR_W];

endmodule

//--- design/fetch_insn_buffer.sv
// one-entry instruction buffer with its valid flag
// plus bus completion delayed by one cycle
module fetch_insn_buffer
   import fetch_pkg::*;
(
   input  logic  clk,
   input  logic  rst,
   input  logic  padv_i,
   input  logic  branch_occur_i,
   input  logic  except_take_i,
   input  logic  ibus_ack_i,
   input  insn_t ibus_dat_i,
   input  logic  bus_done_i,
   output insn_t insn_buf_o,
   output logic  insn_buffered_o,
   output logic  bus_done_r_o
);

   insn_t insn_buf_q;
   logic  insn_buffered_q;
   logic  bus_done_q;
   logic  ack_counted;

   // bus_done already carries the request and redirect gating,
   // so an ack is counted only when it also shows up there
   assign ack_counted = ibus_ack_i & bus_done_i;

   // payload register
   // captures the word of every counted ack
   always_ff @(posedge clk)
   begin
      if (ack_counted)
         insn_buf_q <= ibus_dat_i;
   end

   // buffered flag
   // set when a word arrives that decode is not taking this cycle
   // a word that turns up while a branch waits in execute is wrong path
   always_ff @(posedge clk)
   begin
      if (rst)
         insn_buffered_q <= 1'b0;
      else if (except_take_i)
         insn_buffered_q <= 1'b0;
      else if (ack_counted & ~padv_i & ~branch_occur_i)
         insn_buffered_q <= 1'b1;
      else if (padv_i)
         insn_buffered_q <= 1'b0;
   end

   // completion seen one cycle late to line up with the buffered word
   always_ff @(posedge clk)
   begin
      if (rst)
         bus_done_q <= 1'b0;
      else
         bus_done_q <= bus_done_i;
   end

   assign insn_buf_o = insn_buf_q;
   assign insn_buffered_o = insn_buffered_q;
   assign bus_done_r_o = bus_done_q;

endmodule

//--- design/fetch_pc_unit.sv
// fetch program counter, next pc selection and bus request FSM
module fetch_pc_unit
   import fetch_pkg::*;
(
   input  logic  clk,
   input  logic  rst,
   input  logic  padv_i,
   input  logic  branch_occur_i,
   input  addr_t branch_dest_i,
   input  logic  except_take_i,
   input  logic  du_restart_i,
   input  addr_t du_restart_pc_i,
   input  logic  ibus_ack_i,
   input  logic  ibus_err_i,
   input  logic  insn_buffered_i,
   output addr_t pc_o,
   output logic  ibus_req_o,
   output logic  bus_done_o
);

   addr_t      pc_q;
   fetch_req_e req_state;
   logic       taking_branch;
   logic       ack_counted;
   logic       err_counted;

   // branch is only taken when the pipeline advances past it
   assign taking_branch = branch_occur_i & padv_i;

   // responses count only while the request is up
   // and anything arriving on a redirect cycle is thrown away
   assign bus_done_o = (ibus_ack_i | ibus_err_i) & ibus_req_o & ~taking_branch;
   assign ack_counted = bus_done_o & ~ibus_err_i;
   assign err_counted = bus_done_o & ibus_err_i;

   assign ibus_req_o = (req_state == REQ_ACTIVE);
   assign pc_o = pc_q;

   // debug restart beats exception or branch, which beat sequential fetch
   always_ff @(posedge clk)
   begin
      if (rst)
         pc_q <= RESET_PC;
      else if (du_restart_i)
         pc_q <= du_restart_pc_i;
      else if (except_take_i | taking_branch)
         pc_q <= branch_dest_i;
      // a failed fetch keeps its address for the error handler
      else if (ack_counted)
         pc_q <= pc_q + PC_STEP;
   end

   // request FSM
   always_ff @(posedge clk)
   begin
      if (rst)
         req_state <= REQ_ACTIVE;
      else if (du_restart_i | except_take_i)
         req_state <= REQ_ACTIVE;
      else
      begin
         case (req_state)
            REQ_ACTIVE:
            begin
               // one dead cycle on every taken branch
               if (taking_branch)
                  req_state <= REQ_IDLE;
               else if (err_counted)
                  req_state <= REQ_ERR_WAIT;
               // word lands in the buffer so stop until decode takes it
               else if (ack_counted & ~padv_i)
                  req_state <= REQ_IDLE;
            end
            REQ_IDLE:
            begin
               if (taking_branch)
                  req_state <= REQ_IDLE;
               // resume once the buffer is empty or being drained
               else if (padv_i | ~insn_buffered_i)
                  req_state <= REQ_ACTIVE;
            end
            // only exception entry or restart leaves this state
            REQ_ERR_WAIT:
               req_state <= REQ_ERR_WAIT;
            default:
               req_state <= REQ_ACTIVE;
         endcase
      end
   end

endmodule

//--- design/fetch_pkg.sv
// fetch stage shared types, instruction field positions and constants
// also the bus request state encoding
package fetch_pkg;

   // word and register index widths fixed by the instruction set
   localparam int ADDR_W = 32;
   localparam int INSN_W = 32;
   localparam int RF_ADDR_W = 5;

   // fetch and branch target addresses
   typedef logic [ADDR_W-1:0] addr_t;

   // raw instruction word as returned by the bus
   typedef logic [INSN_W-1:0] insn_t;

   // register file index
   typedef logic [RF_ADDR_W-1:0] rf_addr_t;

   // first fetch address out of reset
   localparam addr_t RESET_PC = 32'h0000_0100;

   // sequential fetch increment of one word
   localparam addr_t PC_STEP = 32'd4;

   // nop opcode sits in the top six bits and all other fields are zero
   localparam logic [5:0] OPCODE_NOP = 6'h15;
   localparam insn_t NOP_INSN = {OPCODE_NOP, 26'd0};

   // low bit of the A and B source register fields
   localparam int RA_LSB = 16;
   localparam int RB_LSB = 11;

   // bus request state
   // active   request held high while waiting for ack or err
   // idle     request low for branch penalty or while a word waits in the buffer
   // err_wait request low after a bus error until exception entry
   typedef enum logic [1:0]
   {
      REQ_ACTIVE,
      REQ_IDLE,
      REQ_ERR_WAIT
   } fetch_req_e;

endpackage

//--- design/fetch_top.sv
// fetch stage top that wires the pc unit, buffer and decode register together
module fetch_top
   import fetch_pkg::*;
(
   input  logic     clk,
   input  logic     rst,
   // pipeline control
   input  logic     padv_i,
   input  logic     branch_occur_i,
   input  addr_t    branch_dest_i,
   input  logic     except_take_i,
   input  logic     du_restart_i,
   input  addr_t    du_restart_pc_i,
   // instruction bus
   input  logic     ibus_ack_i,
   input  logic     ibus_err_i,
   input  insn_t    ibus_dat_i,
   output addr_t    ibus_adr_o,
   output logic     ibus_req_o,
   // decode side
   output insn_t    decode_insn_o,
   output logic     decode_ibus_err_o,
   output logic     fetch_done_o,
   output rf_addr_t fetch_rfa_adr_o,
   output rf_addr_t fetch_rfb_adr_o,
   output addr_t    pc_fetch_o
);

   logic  bus_done;
   logic  bus_done_r;
   logic  insn_buffered;
   insn_t insn_buf;

   fetch_pc_unit i_fetch_pc_unit (
      .clk             (clk),
      .rst             (rst),
      .padv_i          (padv_i),
      .branch_occur_i  (branch_occur_i),
      .branch_dest_i   (branch_dest_i),
      .except_take_i   (except_take_i),
      .du_restart_i    (du_restart_i),
      .du_restart_pc_i (du_restart_pc_i),
      .ibus_ack_i      (ibus_ack_i),
      .ibus_err_i      (ibus_err_i),
      .insn_buffered_i (insn_buffered),
      .pc_o            (pc_fetch_o),
      .ibus_req_o      (ibus_req_o),
      .bus_done_o      (bus_done)
   );

   fetch_insn_buffer i_fetch_insn_buffer (
      .clk             (clk),
      .rst             (rst),
      .padv_i          (padv_i),
      .branch_occur_i  (branch_occur_i),
      .except_take_i   (except_take_i),
      .ibus_ack_i      (ibus_ack_i),
      .ibus_dat_i      (ibus_dat_i),
      .bus_done_i      (bus_done),
      .insn_buf_o      (insn_buf),
      .insn_buffered_o (insn_buffered),
      .bus_done_r_o    (bus_done_r)
   );

   fetch_decode_reg i_fetch_decode_reg (
      .clk               (clk),
      .rst               (rst),
      .padv_i            (padv_i),
      .branch_occur_i    (branch_occur_i),
      .except_take_i     (except_take_i),
      .ibus_err_i        (ibus_err_i),
      .ibus_req_i        (ibus_req_o),
      .insn_buf_i        (insn_buf),
      .insn_buffered_i   (insn_buffered),
      .bus_done_r_i      (bus_done_r),
      .decode_insn_o     (decode_insn_o),
      .decode_ibus_err_o (decode_ibus_err_o),
      .fetch_done_o      (fetch_done_o),
      .fetch_rfa_adr_o   (fetch_rfa_adr_o),
      .fetch_rfb_adr_o   (fetch_rfb_adr_o)
   );

   // bus address is the fetch pc itself
   assign ibus_adr_o = pc_fetch_o;

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the fetch stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module fetch_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

# raise the error limit so assertion failures reach the final report
out=$(./obj_dir/Vfetch_tb +verilator+error+limit+100)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$out" | grep -qx "ALL CHECKS PASSED"; then
   exit 0
fi
exit 1

//--- sources.f
design/fetch_pkg.sv
design/fetch_pc_unit.sv
design/fetch_insn_buffer.sv
design/fetch_decode_reg.sv
design/fetch_top.sv
test/fetch_sva.sv
test/fetch_checker.sv
test/fetch_tb.sv

//--- test/fetch_checker.sv
// reference model of the fetch rules that compares DUT outputs every cycle
// prints one line per finished test and keeps the error counts
module fetch_checker
   import fetch_pkg::*;
(
   input  logic     clk,
   input  logic     rst,
   input  int       test_id_i,
   // DUT inputs
   input  logic     padv_i,
   input  logic     branch_occur_i,
   input  addr_t    branch_dest_i,
   input  logic     except_take_i,
   input  logic     du_restart_i,
   input  addr_t    du_restart_pc_i,
   input  logic     ibus_ack_i,
   input  logic     ibus_err_i,
   input  insn_t    ibus_dat_i,
   // DUT outputs
   input  addr_t    ibus_adr_i,
   input  logic     ibus_req_i,
   input  insn_t    decode_insn_i,
   input  logic     decode_ibus_err_i,
   input  logic     fetch_done_i,
   input  rf_addr_t fetch_rfa_adr_i,
   input  rf_addr_t fetch_rfb_adr_i,
   input  addr_t    pc_fetch_i,
   output int       tests_o,
   output int       errors_o
);

   // model state starts at the reset values
   addr_t      m_pc = RESET_PC;
   fetch_req_e m_req = REQ_ACTIVE;
   insn_t      m_buf = '0;
   insn_t      m_dec = NOP_INSN;
   logic       m_buf_ok = 1'b0;
   logic       m_buffered = 1'b0;
   logic       m_done_r = 1'b0;
   logic       m_err = 1'b0;
   logic       m_br_r = 1'b0;
   logic       m_adv_br = 1'b0;
   logic       m_req_hi;
   logic       m_taking;
   logic       m_done;
   logic       m_fdone;
   int         prev_id = -1;
   int         test_errs = 0;
   int         n_tests = 0;
   int         n_errors = 0;

   assign m_req_hi = (m_req == REQ_ACTIVE);
   assign m_taking = padv_i & branch_occur_i;
   // a response counts only while requesting and not on a redirect
   assign m_done = (ibus_ack_i | ibus_err_i) & m_req_hi & ~m_taking;
   assign m_fdone = (m_done_r | m_buffered) & ~m_adv_br;

   assign tests_o = n_tests;
   assign errors_o = n_errors;

   task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp)
      begin
         $display("MISMATCH %s got %h expected %h at %0t", name, got, exp, $time);
         n_errors++;
         test_errs++;
      end
   endtask

   // inputs are stable mid cycle and outputs show the previous row's effect
   always @(negedge clk)
   begin
      expect_eq("pc_fetch_o", pc_fetch_i, m_pc);
      expect_eq("ibus_adr_o", ibus_adr_i, m_pc);
      expect_eq("ibus_req_o", 32'(ibus_req_i), 32'(m_req_hi));
      expect_eq("decode_insn_o", decode_insn_i, m_dec);
      expect_eq("decode_ibus_err_o", 32'(decode_ibus_err_i), 32'(m_err));
      expect_eq("fetch_done_o", 32'(fetch_done_i), 32'(m_fdone));
      // register fields only mean something once a word was captured
      if (m_buf_ok)
      begin
         expect_eq("fetch_rfa_adr_o", 32'(fetch_rfa_adr_i), 32'(m_buf[RA_LSB +: RF_ADDR_W]));
         expect_eq("fetch_rfb_adr_o", 32'(fetch_rfb_adr_i), 32'(m_buf[RB_LSB +: RF_ADDR_W]));
      end
      if (prev_id >= 0)
      begin
         if (test_errs == 0)
            $display("test %0d ok", prev_id);
         else
            $display("test %0d failed with %0d mismatches", prev_id, test_errs);
         n_tests++;
      end
      test_errs = 0;
      prev_id = test_id_i;

      // next state as the DUT will hold it after the coming edge
      if (rst)
      begin
         m_pc <= RESET_PC;
         m_req <= REQ_ACTIVE;
         m_buffered <= 1'b0;
         m_done_r <= 1'b0;
         m_dec <= NOP_INSN;
         m_err <= 1'b0;
         m_br_r <= 1'b0;
         m_adv_br <= 1'b0;
      end
      else
      begin
         // restart first, then exception or branch, then sequential
         if (du_restart_i)
            m_pc <= du_restart_pc_i;
         else if (except_take_i | m_taking)
            m_pc <= branch_dest_i;
         else if (m_done & ~ibus_err_i)
            m_pc <= m_pc + PC_STEP;
         if (du_restart_i | except_take_i)
            m_req <= REQ_ACTIVE;
         else if (m_req == REQ_ACTIVE)
         begin
            if (m_taking)
               m_req <= REQ_IDLE;
            else if (m_done & ibus_err_i)
               m_req <= REQ_ERR_WAIT;
            else if (m_done & ~padv_i)
               m_req <= REQ_IDLE;
         end
         else if ((m_req == REQ_IDLE) & ~m_taking & (padv_i | ~m_buffered))
            m_req <= REQ_ACTIVE;
         if (m_done & ibus_ack_i)
         begin
            m_buf <= ibus_dat_i;
            m_buf_ok <= 1'b1;
         end
         // a word waits in the buffer when decode does not take it
         if (except_take_i)
            m_buffered <= 1'b0;
         else if (m_done & ibus_ack_i & ~padv_i & ~branch_occur_i)
            m_buffered <= 1'b1;
         else if (padv_i)
            m_buffered <= 1'b0;
         m_done_r <= m_done;
         m_br_r <= branch_occur_i;
         m_adv_br <= padv_i & m_fdone & branch_occur_i;
         if (except_take_i)
            m_dec <= NOP_INSN;
         else if (padv_i & m_fdone & ~m_br_r)
            m_dec <= m_buf;
         if (m_taking)
            m_err <= 1'b0;
         else if (m_req_hi)
            m_err <= ibus_err_i;
      end
   end

endmodule

//--- test/fetch_sva.sv
// bus request assertions for the fetch pc unit
// bound into fetch_pc_unit from the testbench
module fetch_sva
(
   input logic clk,
   input logic rst,
   input logic padv_i,
   input logic branch_occur_i,
   input logic except_take_i,
   input logic du_restart_i,
   input logic ibus_req_i
);

   // read by the testbench at the end of the run
   int   fail_count = 0;
   logic taking;

   // taken branch while requesting unless restart or exception overrides it
   assign taking = padv_i & branch_occur_i & ibus_req_i & ~except_take_i & ~du_restart_i;

   req_after_reset: assert property (@(posedge clk) $fell(rst) |-> ibus_req_i)
   else
   begin
      $error("bus request is low in the first cycle after reset");
      fail_count++;
   end

   // redirect penalty drops the request right after the branch
   branch_drops_req: assert property (@(posedge clk) disable iff (rst)
      taking |=> !ibus_req_i)
   else
   begin
      $error("bus request stayed high after a taken branch");
      fail_count++;
   end

   // and back up one cycle later
   branch_one_cycle: assert property (@(posedge clk) disable iff (rst)
      ($past(taking) && !(padv_i && branch_occur_i)) |=> ibus_req_i)
   else
   begin
      $error("bus request stayed low longer than one cycle after a branch");
      fail_count++;
   end

   except_raises_req: assert property (@(posedge clk) disable iff (rst)
      except_take_i |=> ibus_req_i)
   else
   begin
      $error("bus request not raised after exception entry");
      fail_count++;
   end

endmodule

//--- test/fetch_tb.sv
// fetch stage testbench with clock, reset, stimulus table and lfsr bus data
// plus the checker, assertion bind, watchdog and final report
module fetch_tb
   import fetch_pkg::*;
();

   localparam int CLK_PERIOD = 100;
   localparam int N_ROWS = 24;
   localparam logic [31:0] LFSR_SEED = 32'h0384_458b;

   // ctl bits from high to low are padv, branch, except, restart, ack and err
   typedef struct packed
   {
      logic [5:0] ctl;
      addr_t      dest;
      addr_t      rpc;
   } row_t;

   logic     clk = 1'b0;
   logic     rst;
   logic     padv;
   logic     branch_occur;
   addr_t    branch_dest;
   logic     except_take;
   logic     du_restart;
   addr_t    du_restart_pc;
   logic     ibus_ack;
   logic     ibus_err;
   insn_t    ibus_dat;
   addr_t    ibus_adr;
   logic     ibus_req;
   insn_t    decode_insn;
   logic     decode_ibus_err;
   logic     fetch_done;
   rf_addr_t fetch_rfa_adr;
   rf_addr_t fetch_rfb_adr;
   addr_t    pc_fetch;

   row_t        stim_q[$];
   logic [31:0] lfsr_state = LFSR_SEED;
   int          test_id = -1;
   int          n_tests;
   int          n_errors;
   int          sva_fails;

   always #(CLK_PERIOD / 2) clk = ~clk;

   fetch_top i_fetch_top (
      .clk(clk), .rst(rst),
      .padv_i(padv), .branch_occur_i(branch_occur), .branch_dest_i(branch_dest),
      .except_take_i(except_take), .du_restart_i(du_restart),
      .du_restart_pc_i(du_restart_pc),
      .ibus_ack_i(ibus_ack), .ibus_err_i(ibus_err), .ibus_dat_i(ibus_dat),
      .ibus_adr_o(ibus_adr), .ibus_req_o(ibus_req),
      .decode_insn_o(decode_insn), .decode_ibus_err_o(decode_ibus_err),
      .fetch_done_o(fetch_done), .fetch_rfa_adr_o(fetch_rfa_adr),
      .fetch_rfb_adr_o(fetch_rfb_adr), .pc_fetch_o(pc_fetch)
   );

   fetch_checker i_fetch_checker (
      .clk(clk), .rst(rst), .test_id_i(test_id),
      .padv_i(padv), .branch_occur_i(branch_occur), .branch_dest_i(branch_dest),
      .except_take_i(except_take), .du_restart_i(du_restart),
      .du_restart_pc_i(du_restart_pc),
      .ibus_ack_i(ibus_ack), .ibus_err_i(ibus_err), .ibus_dat_i(ibus_dat),
      .ibus_adr_i(ibus_adr), .ibus_req_i(ibus_req),
      .decode_insn_i(decode_insn), .decode_ibus_err_i(decode_ibus_err),
      .fetch_done_i(fetch_done), .fetch_rfa_adr_i(fetch_rfa_adr),
      .fetch_rfb_adr_i(fetch_rfb_adr), .pc_fetch_i(pc_fetch),
      .tests_o(n_tests), .errors_o(n_errors)
   );

   bind fetch_pc_unit fetch_sva i_fetch_sva (
      .clk(clk), .rst(rst), .padv_i(padv_i), .branch_occur_i(branch_occur_i),
      .except_take_i(except_take_i), .du_restart_i(du_restart_i),
      .ibus_req_i(ibus_req_o)
   );

   // fibonacci lfsr with taps 32 22 2 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   // one lfsr step per data bit
   task automatic draw_word(output insn_t w);
      w = '0;
      for (int b = 0; b < 32; b++)
      begin
         lfsr_state = lfsr_step(lfsr_state);
         w = {w[30:0], lfsr_state[0]};
      end
   endtask

   task automatic add_row(input logic [5:0] ctl, input addr_t dest, input addr_t rpc);
      stim_q.push_back({ctl, dest, rpc});
   endtask

   task automatic apply_row(input row_t r);
      insn_t w;
      draw_word(w);
      padv <= r.ctl[5];
      branch_occur <= r.ctl[4];
      except_take <= r.ctl[3];
      du_restart <= r.ctl[2];
      ibus_ack <= r.ctl[1];
      ibus_err <= r.ctl[0];
      branch_dest <= r.dest;
      du_restart_pc <= r.rpc;
      ibus_dat <= w;
   endtask

   initial
   begin
      rst = 1'b1;
      padv = 1'b0;
      branch_occur = 1'b0;
      branch_dest = '0;
      except_take = 1'b0;
      du_restart = 1'b0;
      du_restart_pc = '0;
      ibus_ack = 1'b0;
      ibus_err = 1'b0;
      ibus_dat = '0;
      // sequential fetch with decode advancing
      add_row(6'b100010, 32'h0, 32'h0);
      add_row(6'b100010, 32'h0, 32'h0);
      add_row(6'b100000, 32'h0, 32'h0);
      // back-pressure holds the word in the buffer and an ack while idle is ignored
      add_row(6'b000010, 32'h0, 32'h0);
      add_row(6'b000000, 32'h0, 32'h0);
      add_row(6'b000010, 32'h0, 32'h0);
      add_row(6'b100000, 32'h0, 32'h0);
      add_row(6'b100010, 32'h0, 32'h0);
      // taken branch then an ack in the dead cycle
      add_row(6'b110000, 32'h0000_0200, 32'h0);
      add_row(6'b000010, 32'h0, 32'h0);
      add_row(6'b100010, 32'h0, 32'h0);
      add_row(6'b100010, 32'h0, 32'h0);
      // bus error keeps the request down until exception entry
      add_row(6'b100001, 32'h0, 32'h0);
      add_row(6'b100000, 32'h0, 32'h0);
      add_row(6'b000010, 32'h0, 32'h0);
      add_row(6'b101000, 32'h0000_0800, 32'h0);
      add_row(6'b100010, 32'h0, 32'h0);
      // restart wins over a simultaneous exception
      add_row(6'b101100, 32'h0000_0900, 32'h0000_0400);
      // stall the request with a buffered word, then restart alone lifts it
      add_row(6'b000010, 32'h0, 32'h0);
      add_row(6'b000100, 32'h0, 32'h0000_0300);
      add_row(6'b100010, 32'h0, 32'h0);
      add_row(6'b100010, 32'h0, 32'h0);
      add_row(6'b000000, 32'h0, 32'h0);
      add_row(6'b100010, 32'h0, 32'h0);
      repeat (5) @(posedge clk);
      rst <= 1'b0;
      for (int i = 0; i < stim_q.size(); i++)
      begin
         @(posedge clk);
         apply_row(stim_q[i]);
         test_id <= i;
      end
      @(posedge clk);
      apply_row('0);
      test_id <= -1;
      // the checker reports the last row on the falling edge before this
      @(posedge clk);
      sva_fails = i_fetch_top.i_fetch_pc_unit.i_fetch_sva.fail_count;
      $display("tests %0d of %0d, mismatches %0d, assertion failures %0d",
               n_tests, N_ROWS, n_errors, sva_fails);
      if (n_tests != N_ROWS)
         $display("only %0d of %0d tests were reported", n_tests, N_ROWS);
      if (n_errors == 0 && sva_fails == 0 && n_tests == N_ROWS)
         $display("ALL CHECKS PASSED");
      else
         $display("CHECKS FAILED");
      $finish;
   end

   // reset, table and drain fit well inside twenty spare cycles
   initial
   begin
      #((N_ROWS + 20) * CLK_PERIOD);
      $display("timeout, the stimulus table did not finish in time");
      $display("CHECKS FAILED");
      $finish;
   end

endmodule
